// ==== verilog/phold_defines.svh ====
`ifndef PHOLD_DEFINES_SVH
`define PHOLD_DEFINES_SVH

// Event fields
`define TW 16 // Timestamp width
`define NIDB 3 // Process id width, NUM_LP <= 2**NIDB
`define NRB 8 // Random number width

// Queues and state storage
`define EVQ_DEPTH 4 // Entries per event FIFO
`define NUM_LP 8
`define REC_QUADS 2 // Quads in one process state record

// Smallest distance between an event and the one it spawns
`define MIN_GAP 10

`endif

// ==== verilog/pdes_pkg.sv ====
`include "phold_defines.svh"

package pdes_pkg;

	// Simulation time
	typedef logic [`TW-1:0] time_t;

	// Logical process id
	typedef logic [`NIDB-1:0] lp_id_t;

	// One LFSR sample
	typedef logic [`NRB-1:0] rnd_t;

	// Id sits above the timestamp, same as in the state record
	typedef struct packed {
		lp_id_t id;
		time_t ts;
	} event_t;

endpackage

// ==== verilog/mc_pkg.sv ====
package mc_pkg;

	// Request commands toward the state memory
	typedef enum logic [2:0] {
		MC_CMD_IDLE = 3'd0,
		MC_CMD_RD8 = 3'd1, // Read one quad
		MC_CMD_WR8 = 3'd2 // Write one quad
	} mc_cmd_e;

	// Response commands back to the core
	typedef enum logic [2:0] {
		MC_RSP_RD8_DATA = 3'd2,
		MC_RSP_WR_CMP = 3'd3
	} mc_rsp_e;

	// Quad address, {process id, quad index}
	typedef logic [3:0] mc_adr_t;

	// Echoed with the response, picks the quad of the record
	typedef logic rtnctl_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/100ps
`include "phold_defines.svh"

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = `EVQ_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input item_t din,
	input logic pop,
	output item_t dout,
	output logic full,
	output logic empty
);
	localparam int AW = $clog2(DEPTH);

	item_t buf_q [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count; // Occupancy
	logic do_push;
	logic do_pop;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full; // Overflow is dropped
	assign do_pop = pop && !empty;
	assign dout = buf_q[rd_ptr]; // Head of queue

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			buf_q[wr_ptr] <= din;
	end

endmodule

// ==== verilog/rng_lfsr.sv ====
`timescale 1ns/100ps

module rng_lfsr (
	input logic clk,
	input logic rst,
	input logic step,
	output pdes_pkg::rnd_t rnd
);
	import pdes_pkg::*;

	rnd_t next_rnd;

	// Galois form of x^8+x^6+x^5+x^4+1, shifting right
	always_comb begin
		next_rnd = {1'b0, rnd[7:1]};
		if (rnd[0])
			next_rnd = next_rnd ^ 8'hB8; // Feedback taps
	end

	always_ff @(posedge clk) begin
		if (rst)
			rnd <= 8'h01; // Any nonzero seed works
		else if (step)
			rnd <= next_rnd; // One step per accepted event
	end

endmodule

// ==== verilog/phold_core.sv ====
`timescale 1ns/100ps
`include "phold_defines.svh"

module phold_core (
	input logic clk,
	input logic rst,
	input logic event_valid,
	input pdes_pkg::event_t event_in,
	input pdes_pkg::rnd_t random_in,
	output logic ready,
	output logic new_event_ready,
	output pdes_pkg::event_t new_event,
	input logic ack,
	output logic rq_vld,
	output mc_pkg::mc_cmd_e rq_cmd,
	output mc_pkg::mc_adr_t rq_adr,
	output mc_pkg::rtnctl_t rq_rtnctl,
	output logic [63:0] rq_data,
	input logic rq_stall,
	input logic rs_vld,
	input mc_pkg::mc_rsp_e rs_cmd,
	input mc_pkg::rtnctl_t rs_rtnctl,
	input logic [63:0] rs_data
);
	import pdes_pkg::*;
	import mc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LD_MEM,
		S_LD_RTN,
		S_DELAY,
		S_ST_MEM,
		S_ST_RTN,
		S_WAIT
	} state_t;

	state_t state;
	event_t cur_ev; // Event being processed
	rnd_t cur_rnd; // Its random byte
	logic [63:0] rec [`REC_QUADS]; // State record of the target process
	logic [`REC_QUADS-1:0] got; // Responses seen per quad
	logic [2:0] dly_cnt;

	// Responses are taken into flops before use
	logic r_rs_vld;
	mc_rsp_e r_rs_cmd;
	rtnctl_t r_rs_rtnctl;
	logic [63:0] r_rs_data;

	mc_rsp_e exp_rsp;
	logic rq_accept;
	logic last_quad;
	logic rsp_hit;
	logic rec_done;

	assign ready = (state == S_IDLE);
	assign rq_accept = rq_vld && !rq_stall;
	assign last_quad = (rq_rtnctl == rtnctl_t'(`REC_QUADS-1));
	assign rec_done = &got;

	always_comb begin
		if (state == S_LD_MEM || state == S_LD_RTN)
			exp_rsp = MC_RSP_RD8_DATA;
		else
			exp_rsp = MC_RSP_WR_CMP;
	end
	assign rsp_hit = r_rs_vld && (r_rs_cmd == exp_rsp);

	// Record lives at {id, quad}; written back with the event in the low bits
	assign rq_adr = mc_adr_t'({cur_ev.id, rq_rtnctl});
	assign rq_data = {rec[rq_rtnctl][63:`TW+`NIDB], cur_ev};

	// Spawned event, target from the top bits and gap from the low ones
	assign new_event = '{
		id: cur_rnd[`NRB-1:`NRB-`NIDB],
		ts: cur_ev.ts + time_t'(`MIN_GAP) + time_t'(cur_rnd[`NRB-`NIDB-1:0])
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			rq_vld <= 1'b0;
			rq_cmd <= MC_CMD_IDLE;
			rq_rtnctl <= '0;
			got <= '0;
			dly_cnt <= '0;
			new_event_ready <= 1'b0;
			r_rs_vld <= 1'b0;
		end else begin
			r_rs_vld <= rs_vld;
			if (rsp_hit)
				got[r_rs_rtnctl] <= 1'b1;
			case (state)
				S_IDLE: if (event_valid) begin
					state <= S_LD_MEM;
					rq_vld <= 1'b1;
					rq_cmd <= MC_CMD_RD8;
					rq_rtnctl <= '0;
				end
				S_LD_MEM, S_ST_MEM: if (rq_accept) begin
					if (last_quad) begin // Both quads issued
						rq_vld <= 1'b0;
						rq_cmd <= MC_CMD_IDLE;
						if (state == S_LD_MEM)
							state <= S_LD_RTN;
						else
							state <= S_ST_RTN;
					end else begin
						rq_rtnctl <= rq_rtnctl + 1'b1;
					end
				end
				S_LD_RTN: if (rec_done) begin
					got <= '0;
					dly_cnt <= '0;
					state <= S_DELAY;
				end
				S_DELAY: begin
					// Processing time of rnd[2:0] + 1 cycles
					if (dly_cnt == cur_rnd[2:0]) begin
						state <= S_ST_MEM;
						rq_vld <= 1'b1;
						rq_cmd <= MC_CMD_WR8;
						rq_rtnctl <= '0;
					end else begin
						dly_cnt <= dly_cnt + 1'b1;
					end
				end
				S_ST_RTN: if (rec_done) begin
					got <= '0;
					state <= S_WAIT;
					new_event_ready <= 1'b1;
				end
				S_WAIT: if (ack) begin // Output queue took the event
					state <= S_IDLE;
					new_event_ready <= 1'b0;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		r_rs_cmd <= rs_cmd;
		r_rs_rtnctl <= rs_rtnctl;
		r_rs_data <= rs_data;
		if (event_valid && ready) begin
			cur_ev <= event_in;
			cur_rnd <= random_in; // Value from before the LFSR step
		end
		if (rsp_hit && r_rs_cmd == MC_RSP_RD8_DATA)
			rec[r_rs_rtnctl] <= r_rs_data;
	end

endmodule

// ==== verilog/lp_state_mem.sv ====
`timescale 1ns/100ps
`include "phold_defines.svh"

module lp_state_mem (
	input logic clk,
	input logic rst,
	input logic rq_vld,
	input mc_pkg::mc_cmd_e rq_cmd,
	input mc_pkg::mc_adr_t rq_adr,
	input mc_pkg::rtnctl_t rq_rtnctl,
	input logic [63:0] rq_data,
	output logic rq_stall,
	output logic rs_vld,
	output mc_pkg::mc_rsp_e rs_cmd,
	output mc_pkg::rtnctl_t rs_rtnctl,
	output logic [63:0] rs_data
);
	import mc_pkg::*;

	localparam int NQ = `NUM_LP * `REC_QUADS;

	logic [63:0] mem [NQ];
	logic accept;
	logic is_wr;

	// First response stage
	logic s0_vld;
	mc_rsp_e s0_cmd;
	rtnctl_t s0_rtnctl;
	logic [63:0] s0_data;

	assign accept = rq_vld && !rq_stall;
	assign is_wr = (rq_cmd == MC_CMD_WR8);

	always_ff @(posedge clk) begin
		if (rst) begin
			rq_stall <= 1'b0;
			s0_vld <= 1'b0;
			rs_vld <= 1'b0;
		end else begin
			rq_stall <= accept; // One dead cycle after each request
			s0_vld <= accept;
			rs_vld <= s0_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s0_cmd <= is_wr ? MC_RSP_WR_CMP : MC_RSP_RD8_DATA;
			s0_rtnctl <= rq_rtnctl; // Echoed back unchanged
			s0_data <= is_wr ? rq_data : mem[rq_adr];
			if (is_wr)
				mem[rq_adr] <= rq_data;
		end
		rs_cmd <= s0_cmd;
		rs_rtnctl <= s0_rtnctl;
		rs_data <= s0_data;
	end

endmodule

// ==== verilog/phold_node.sv ====
`timescale 1ns/100ps

module phold_node (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input pdes_pkg::lp_id_t in_id,
	input pdes_pkg::time_t in_time,
	output logic in_ready,
	output logic out_valid,
	output pdes_pkg::time_t out_time,
	output pdes_pkg::lp_id_t out_target,
	input logic out_ack
);
	import pdes_pkg::*;
	import mc_pkg::*;

	event_t in_ev;
	event_t head_ev;
	event_t new_ev;
	event_t out_ev;
	logic in_full;
	logic in_empty;
	logic out_full;
	logic out_empty;
	logic core_ready;
	logic ev_take; // Pop into the core, also steps the LFSR
	logic new_rdy;
	rnd_t rnd;

	logic rq_vld;
	mc_cmd_e rq_cmd;
	mc_adr_t rq_adr;
	rtnctl_t rq_rtnctl;
	logic [63:0] rq_data;
	logic rq_stall;
	logic rs_vld;
	mc_rsp_e rs_cmd;
	rtnctl_t rs_rtnctl;
	logic [63:0] rs_data;

	assign in_ready = !in_full;
	assign in_ev = '{id: in_id, ts: in_time};
	assign ev_take = core_ready && !in_empty;

	assign out_valid = !out_empty;
	assign out_time = out_ev.ts;
	assign out_target = out_ev.id;

	sync_fifo #(.item_t(event_t)) ev_in_q (
		.clk(clk), .rst(rst),
		.push(in_valid && in_ready), .din(in_ev),
		.pop(ev_take), .dout(head_ev),
		.full(in_full), .empty(in_empty)
	);

	rng_lfsr rng0 (.clk(clk), .rst(rst), .step(ev_take), .rnd(rnd));

	phold_core core0 (
		.clk(clk), .rst(rst),
		.event_valid(ev_take), .event_in(head_ev), .random_in(rnd), .ready(core_ready),
		.new_event_ready(new_rdy), .new_event(new_ev), .ack(!out_full),
		.rq_vld(rq_vld), .rq_cmd(rq_cmd), .rq_adr(rq_adr), .rq_rtnctl(rq_rtnctl),
		.rq_data(rq_data), .rq_stall(rq_stall),
		.rs_vld(rs_vld), .rs_cmd(rs_cmd), .rs_rtnctl(rs_rtnctl), .rs_data(rs_data)
	);

	lp_state_mem mem0 (
		.clk(clk), .rst(rst),
		.rq_vld(rq_vld), .rq_cmd(rq_cmd), .rq_adr(rq_adr), .rq_rtnctl(rq_rtnctl),
		.rq_data(rq_data), .rq_stall(rq_stall),
		.rs_vld(rs_vld), .rs_cmd(rs_cmd), .rs_rtnctl(rs_rtnctl), .rs_data(rs_data)
	);

	// Core holds new_rdy until there is room here
	sync_fifo #(.item_t(event_t)) ev_out_q (
		.clk(clk), .rst(rst),
		.push(new_rdy && !out_full), .din(new_ev),
		.pop(out_ack), .dout(out_ev),
		.full(out_full), .empty(out_empty)
	);

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);
	initial clk = 1'b0;

	always #2 clk = ~clk; // 4 ns period

endmodule

// ==== bench/phold_node_sva.sv ====
`timescale 1ns/100ps

module phold_node_sva (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_ready,
	input logic out_valid,
	input logic out_ack,
	input pdes_pkg::time_t out_time,
	input pdes_pkg::lp_id_t out_target
);
	logic pushed; // Set by the first accepted input
	int unsigned fail_cnt = 0; // Failed assertions so far

	always_ff @(posedge clk) begin
		if (rst)
			pushed <= 1'b0;
		else if (in_valid && in_ready)
			pushed <= 1'b1;
	end

	// Reset leaves the node empty and open
	reset_state: assert property (@(posedge clk) rst |=> !out_valid && in_ready)
		else begin
			fail_cnt++;
			$error("out_valid or in_ready wrong right after reset");
		end

	idle_before_push: assert property (@(posedge clk) disable iff (rst)
		!pushed |-> in_ready && !out_valid)
		else begin
			fail_cnt++;
			$error("out_valid or in_ready changed before the first push");
		end

	// Head of the output queue holds while not acknowledged
	hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ack |=> out_valid && $stable(out_time) && $stable(out_target))
		else begin
			fail_cnt++;
			$error("output event changed while out_ack was low");
		end

endmodule

// ==== bench/phold_node_tb.sv ====
`timescale 1ns/100ps
`include "phold_defines.svh"

module phold_node_tb;
	import pdes_pkg::*;

	localparam int WAIT_LIMIT = 500; // Longest any wait may last, in cycles
	localparam int PRE_EVENTS = 20;
	localparam int POST_EVENTS = 20;

	logic clk;
	logic rst;
	logic in_valid;
	lp_id_t in_id;
	time_t in_time;
	logic in_ready;
	logic out_valid;
	time_t out_time;
	lp_id_t out_target;
	logic out_ack;
	logic hold_ack; // Long back-pressure stretch
	logic send_done;
	rnd_t model_rnd; // Software copy of the LFSR
	int sent_cnt;
	int rcvd_cnt;
	event_t exp_q[$]; // Expected outputs in input order

	tb_clock clk_gen (.clk(clk));

	phold_node dut0 (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_id(in_id), .in_time(in_time), .in_ready(in_ready),
		.out_valid(out_valid), .out_time(out_time), .out_target(out_target),
		.out_ack(out_ack)
	);

	bind phold_node phold_node_sva sva0 (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
		.out_valid(out_valid), .out_ack(out_ack), .out_time(out_time),
		.out_target(out_target)
	);

	function automatic rnd_t lfsr_step(rnd_t v);
		// Right shift, taps 8'hB8 folded in when bit 0 drops out
		return v[0] ? ({1'b0, v[7:1]} ^ 8'hB8) : {1'b0, v[7:1]};
	endfunction

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// One input pushed at the next rising edge, expectation recorded now
	task automatic drive_one();
		event_t exp;
		in_valid = 1'b1;
		in_id = lp_id_t'($urandom);
		in_time = time_t'($urandom);
		exp.id = model_rnd[7:5]; // Target from the top three bits
		exp.ts = in_time + time_t'(`MIN_GAP) + time_t'(model_rnd[4:0]);
		exp_q.push_back(exp);
		model_rnd = lfsr_step(model_rnd);
		sent_cnt++;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic push_event();
		int waited;
		waited = 0;
		if ($urandom_range(0, 3) == 0)
			@(negedge clk); // Random gap
		while (!in_ready) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				stop_with_failure("in_ready stayed low while sending events");
		end
		drive_one();
	endtask

	task automatic send_events();
		int n;
		for (int i = 0; i < PRE_EVENTS; i++)
			push_event();
		hold_ack = 1'b1;
		n = 0;
		while (in_ready) begin // Fill the node until it pushes back
			drive_one();
			n++;
			if (n > WAIT_LIMIT)
				stop_with_failure("in_ready never fell while out_ack was held low");
		end
		repeat (40) @(negedge clk);
		hold_ack = 1'b0;
		for (int i = 0; i < POST_EVENTS; i++)
			push_event();
		send_done = 1'b1;
	endtask

	task automatic check_output();
		event_t exp;
		if (exp_q.size() == 0)
			stop_with_failure("an output event appeared with no input left to match it");
		exp = exp_q.pop_front();
		assert (out_time == exp.ts)
			else stop_with_failure($sformatf("Error: out_time is %h, expected %h",
				out_time, exp.ts));
		assert (out_target == exp.id)
			else stop_with_failure($sformatf("Error: out_target is %h, expected %h",
				out_target, exp.id));
		rcvd_cnt++;
	endtask

	task automatic collect_events();
		int idle;
		idle = 0;
		while (!(send_done && rcvd_cnt == sent_cnt)) begin
			@(negedge clk);
			if (out_valid && !hold_ack && $urandom_range(0, 2) != 0) begin
				check_output();
				out_ack = 1'b1; // Pop at the next rising edge
				idle = 0;
			end else begin
				out_ack = 1'b0;
				idle++;
				if (idle > WAIT_LIMIT)
					stop_with_failure("no output event was taken for too long");
			end
		end
		@(negedge clk);
		out_ack = 1'b0;
	endtask

	always @(negedge clk) begin
		if (dut0.sva0.fail_cnt != 0)
			stop_with_failure("a bound assertion on the node outputs failed");
	end

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_id = '0;
		in_time = '0;
		out_ack = 1'b0;
		hold_ack = 1'b0;
		send_done = 1'b0;
		sent_cnt = 0;
		rcvd_cnt = 0;
		model_rnd = 8'h01; // LFSR value out of reset
		void'($urandom(32'h8792_dc19));
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fork
			send_events();
			collect_events();
		join
		// Every input is matched, so the output queue must now be empty
		if (!out_valid && dut0.sva0.fail_cnt == 0) begin
			$display(">>> PASS");
			$finish;
		end else if (out_valid) begin
			stop_with_failure("an extra output event was left after all inputs were matched");
		end else begin
			stop_with_failure("a bound assertion on the node outputs failed");
		end
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/pdes_pkg.sv
verilog/mc_pkg.sv
verilog/sync_fifo.sv
verilog/rng_lfsr.sv
verilog/phold_core.sv
verilog/lp_state_mem.sv
verilog/phold_node.sv
bench/tb_clock.sv
bench/phold_node_sva.sv
bench/phold_node_tb.sv
